// ==== design/access_arbiter.sv ====
/* Access arbiter
 * Takes one request at a time with data over fetch priority, decodes the
 * data address and counts the access delay before firing the target
 */
module access_arbiter #(
    parameter int unsigned instr_fetch_delay = 3,
    parameter int unsigned data_access_delay = 2,
    parameter int unsigned ram_bytes         = 16384
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_req,
    input  mem_ctl_pkg::addr_t       instr_addr,
    input  mem_ctl_pkg::addr_t       mem_addr,
    input  mem_ctl_pkg::word_t       mem_wdata,
    input  mem_ctl_pkg::store_size_t mem_wflag,
    input  logic                     mem_we,
    input  logic                     mem_re,
    output mem_ctl_pkg::addr_t       acc_addr,
    output mem_ctl_pkg::word_t       acc_wdata,
    output mem_ctl_pkg::store_size_t acc_size,
    output logic                     acc_we,
    output logic                     ram_fire,
    output logic                     uart_fire,
    output logic                     resp_valid,
    output logic                     resp_is_instr,
    output logic                     resp_we,
    output mem_ctl_pkg::target_e     resp_target
);

    localparam int unsigned max_delay = (instr_fetch_delay > data_access_delay) ?
                                        instr_fetch_delay : data_access_delay;
    // Counter only ever holds delay minus one
    localparam int cnt_w = (max_delay > 1) ? $clog2(max_delay) : 1;
    localparam mem_ctl_pkg::addr_t ram_limit = mem_ctl_pkg::addr_t'(ram_bytes);

    mem_ctl_pkg::arb_state_e state_q;
    mem_ctl_pkg::target_e    target_q;
    mem_ctl_pkg::target_e    data_target;
    logic [cnt_w-1:0]        cnt_q;
    logic                    is_instr_q;
    logic                    data_req;
    logic                    done;

    assign data_req = mem_we || mem_re;

    // ============================================================
    // Data address decode
    // ============================================================
    always_comb begin
        if (mem_addr >= mem_ctl_pkg::uart_base && mem_addr < mem_ctl_pkg::uart_limit) begin
            data_target = mem_ctl_pkg::tgt_uart;
        end else if (mem_addr >= mem_ctl_pkg::data_base && mem_addr < ram_limit) begin
            data_target = mem_ctl_pkg::tgt_ram;
        end else begin
            data_target = mem_ctl_pkg::tgt_none;
        end
    end

    // ============================================================
    // Arbiter FSM and delay counter
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= mem_ctl_pkg::st_idle;
            cnt_q      <= '0;
            target_q   <= mem_ctl_pkg::tgt_none;
            is_instr_q <= 1'b0;
            acc_we     <= 1'b0;
        end else begin
            case (state_q)
                mem_ctl_pkg::st_idle: begin
                    if (data_req) begin
                        target_q   <= data_target;
                        is_instr_q <= 1'b0;
                        acc_we     <= mem_we;
                        cnt_q      <= cnt_w'(data_access_delay - 1);
                        state_q    <= mem_ctl_pkg::st_wait;
                    end else if (instr_req) begin
                        // Fetches may hit any RAM address
                        target_q   <= mem_ctl_pkg::tgt_ram;
                        is_instr_q <= 1'b1;
                        acc_we     <= 1'b0;
                        cnt_q      <= cnt_w'(instr_fetch_delay - 1);
                        state_q    <= mem_ctl_pkg::st_wait;
                    end
                end
                mem_ctl_pkg::st_wait: begin
                    if (cnt_q == '0) begin
                        state_q <= mem_ctl_pkg::st_respond;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                mem_ctl_pkg::st_respond: begin
                    state_q <= mem_ctl_pkg::st_idle;
                end
                default: state_q <= mem_ctl_pkg::st_idle;
            endcase
        end
    end

    // Latched request payload
    always_ff @(posedge clk) begin
        if (state_q == mem_ctl_pkg::st_idle) begin
            if (data_req) begin
                acc_addr  <= mem_addr;
                acc_wdata <= mem_wdata;
                acc_size  <= mem_wflag;
            end else if (instr_req) begin
                acc_addr  <= instr_addr;
                acc_wdata <= '0;
                acc_size  <= mem_ctl_pkg::size_word;
            end
        end
    end

    // Completion strobes, all in the last wait cycle
    assign done          = (state_q == mem_ctl_pkg::st_wait) && (cnt_q == '0);
    assign resp_valid    = done;
    assign ram_fire      = done && (target_q == mem_ctl_pkg::tgt_ram);
    assign uart_fire     = done && (target_q == mem_ctl_pkg::tgt_uart);
    assign resp_is_instr = is_instr_q;
    assign resp_we       = acc_we;
    assign resp_target   = target_q;

    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(cnt_q) < int'(max_delay));

    // Latched target and latched address must agree
    a_uart_fire_addr: assert property (@(posedge clk) disable iff (!rst_n)
        uart_fire |-> (acc_addr >= mem_ctl_pkg::uart_base && acc_addr < mem_ctl_pkg::uart_limit));

endmodule

// ==== design/byte_lane_ram.sv ====
/* Unified byte-addressed RAM
 * Little-endian word reads and byte, halfword or word writes by store size
 */
module byte_lane_ram #(
    parameter int unsigned ram_bytes = 16384
) (
    input  logic                     clk,
    input  mem_ctl_pkg::addr_t       acc_addr,
    input  mem_ctl_pkg::word_t       acc_wdata,
    input  mem_ctl_pkg::store_size_t acc_size,
    input  logic                     ram_fire,
    input  logic                     acc_we,
    output mem_ctl_pkg::word_t       ram_rdata
);

    localparam int idx_w = $clog2(ram_bytes);

    mem_ctl_pkg::byte_t mem [ram_bytes];
    logic [idx_w-1:0]   lane_addr [4];
    logic [3:0]         lane_en;

    // Byte addresses of the four lanes, wrapping at the top of RAM
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_addr[i] = acc_addr[idx_w-1:0] + idx_w'(i);
        end
    end

    // Lanes written per store size
    always_comb begin
        case (acc_size)
            mem_ctl_pkg::size_half: lane_en = 4'b0011;
            mem_ctl_pkg::size_word: lane_en = 4'b1111;
            default:                lane_en = 4'b0001;
        endcase
    end

    // ============================================================
    // Write port
    // ============================================================
    always_ff @(posedge clk) begin
        if (ram_fire && acc_we) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) begin
                    mem[lane_addr[i]] <= acc_wdata[8*i +: 8];
                end
            end
        end
    end

    // ============================================================
    // Read port
    // ============================================================
    assign ram_rdata = {mem[lane_addr[3]], mem[lane_addr[2]],
                        mem[lane_addr[1]], mem[lane_addr[0]]};

    // Decode upstream must keep writes inside the array
    a_write_in_range: assert property (@(posedge clk)
        (ram_fire && acc_we) |-> (acc_addr < mem_ctl_pkg::addr_t'(ram_bytes)));

endmodule

// ==== design/mem_ctl.sv ====
/* Memory controller top
 * Unified RAM and UART TX registers behind one delayed access arbiter
 */
module mem_ctl #(
    parameter int unsigned instr_fetch_delay = 3,
    parameter int unsigned data_access_delay = 2,
    parameter int unsigned ram_bytes         = 16384
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // Instruction port
    input  logic                     instr_req,
    input  mem_ctl_pkg::addr_t       instr_addr,
    output mem_ctl_pkg::word_t       instr_data,
    output logic                     instr_ready,
    // Data port
    input  mem_ctl_pkg::addr_t       mem_addr,
    input  mem_ctl_pkg::word_t       mem_wdata,
    input  mem_ctl_pkg::store_size_t mem_wflag,
    input  logic                     mem_we,
    input  logic                     mem_re,
    output mem_ctl_pkg::word_t       mem_rdata,
    output logic                     mem_ready,
    // UART transmitter
    output logic                     uart_tx_en,
    input  logic                     uart_tx_busy,
    output mem_ctl_pkg::byte_t       uart_tx_data
);

    mem_ctl_pkg::addr_t       acc_addr;
    mem_ctl_pkg::word_t       acc_wdata;
    mem_ctl_pkg::store_size_t acc_size;
    logic                     acc_we;
    logic                     ram_fire;
    logic                     uart_fire;
    logic                     resp_valid;
    logic                     resp_is_instr;
    logic                     resp_we;
    mem_ctl_pkg::target_e     resp_target;
    mem_ctl_pkg::word_t       ram_rdata;
    mem_ctl_pkg::word_t       uart_rdata;

    access_arbiter #(
        .instr_fetch_delay (instr_fetch_delay),
        .data_access_delay (data_access_delay),
        .ram_bytes         (ram_bytes)
    ) access_arbiter_i (
        .clk, .rst_n, .instr_req, .instr_addr,
        .mem_addr, .mem_wdata, .mem_wflag, .mem_we, .mem_re,
        .acc_addr, .acc_wdata, .acc_size, .acc_we,
        .ram_fire, .uart_fire,
        .resp_valid, .resp_is_instr, .resp_we, .resp_target
    );

    byte_lane_ram #(
        .ram_bytes (ram_bytes)
    ) byte_lane_ram_i (
        .clk, .acc_addr, .acc_wdata, .acc_size, .ram_fire, .acc_we, .ram_rdata
    );

    uart_tx_regs uart_tx_regs_i (
        .clk, .rst_n, .acc_addr, .acc_wdata, .acc_we, .uart_fire,
        .uart_tx_busy, .uart_tx_en, .uart_tx_data, .uart_rdata
    );

    response_stage response_stage_i (
        .clk, .rst_n, .resp_valid, .resp_is_instr, .resp_we, .resp_target,
        .ram_rdata, .uart_rdata,
        .instr_data, .instr_ready, .mem_rdata, .mem_ready
    );

endmodule

// ==== design/mem_ctl_pkg.sv ====
/* Memory controller package
 * Shared bus types, store size codes, data address map and FSM states
 */
package mem_ctl_pkg;

    // ============================================================
    // Bus types
    // ============================================================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // funct3 of the store instruction
    typedef logic [2:0]  store_size_t;

    // ============================================================
    // Store size codes
    // ============================================================
    localparam store_size_t size_byte = 3'd0;
    localparam store_size_t size_half = 3'd1;
    localparam store_size_t size_word = 3'd2;

    // ============================================================
    // Data address map
    // ============================================================
    localparam addr_t data_base      = 32'h0000_2000;
    localparam addr_t uart_base      = 32'h0000_4000;
    localparam addr_t uart_limit     = 32'h0000_4100;
    localparam addr_t uart_data_addr = 32'h0000_4000;
    localparam addr_t uart_ctrl_addr = 32'h0000_4004;

    // Decoded destination of a data access
    typedef enum logic [1:0] {
        tgt_ram,
        tgt_uart,
        tgt_none
    } target_e;

    // Arbiter FSM
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_respond
    } arb_state_e;

endpackage

// ==== design/response_stage.sv ====
/* Response stage
 * Registers read data and returns one-cycle ready pulses to the core
 */
module response_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 resp_valid,
    input  logic                 resp_is_instr,
    input  logic                 resp_we,
    input  mem_ctl_pkg::target_e resp_target,
    input  mem_ctl_pkg::word_t   ram_rdata,
    input  mem_ctl_pkg::word_t   uart_rdata,
    output mem_ctl_pkg::word_t   instr_data,
    output logic                 instr_ready,
    output mem_ctl_pkg::word_t   mem_rdata,
    output logic                 mem_ready
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_data  <= '0;
            instr_ready <= 1'b0;
            mem_rdata   <= '0;
            mem_ready   <= 1'b0;
        end else begin
            instr_ready <= 1'b0;
            mem_ready   <= 1'b0;
            if (resp_valid) begin
                if (resp_is_instr) begin
                    instr_data  <= ram_rdata;
                    instr_ready <= 1'b1;
                end else begin
                    mem_ready <= 1'b1;
                    // Stores keep the last read value
                    if (!resp_we) begin
                        case (resp_target)
                            mem_ctl_pkg::tgt_ram:  mem_rdata <= ram_rdata;
                            mem_ctl_pkg::tgt_uart: mem_rdata <= uart_rdata;
                            default:               mem_rdata <= '0;
                        endcase
                    end
                end
            end
        end
    end

    // Ready is a one-cycle pulse per access
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_ready || mem_ready) |=> !(instr_ready || mem_ready));

endmodule

// ==== design/uart_tx_regs.sv ====
/* UART transmit registers
 * TX data and control registers with a busy status read
 */
module uart_tx_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_ctl_pkg::addr_t acc_addr,
    input  mem_ctl_pkg::word_t acc_wdata,
    input  logic               acc_we,
    input  logic               uart_fire,
    input  logic               uart_tx_busy,
    output logic               uart_tx_en,
    output mem_ctl_pkg::byte_t uart_tx_data,
    output mem_ctl_pkg::word_t uart_rdata
);

    logic wr_data;
    logic wr_ctrl;

    assign wr_data = uart_fire && acc_we && (acc_addr == mem_ctl_pkg::uart_data_addr);
    assign wr_ctrl = uart_fire && acc_we && (acc_addr == mem_ctl_pkg::uart_ctrl_addr);

    // ============================================================
    // Register writes
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_tx_data <= '0;
            uart_tx_en   <= 1'b0;
        end else begin
            // Enable is a strobe and drops by itself
            uart_tx_en <= 1'b0;
            if (wr_data) begin
                uart_tx_data <= acc_wdata[7:0];
            end
            if (wr_ctrl) begin
                uart_tx_en <= acc_wdata[1];
            end
        end
    end

    // ============================================================
    // Status read
    // ============================================================
    // Busy flag in bit 0, data register is write-only
    always_comb begin
        if (acc_addr == mem_ctl_pkg::uart_ctrl_addr) begin
            uart_rdata = {31'b0, uart_tx_busy};
        end else begin
            uart_rdata = '0;
        end
    end

    a_tx_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        uart_tx_en |=> !uart_tx_en);

endmodule

// ==== mem_ctl.f ====
+incdir+tb
design/mem_ctl_pkg.sv
design/access_arbiter.sv
design/byte_lane_ram.sv
design/uart_tx_regs.sv
design/response_stage.sv
design/mem_ctl.sv
tb/tb_mem_ctl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the memory controller testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_ctl -f mem_ctl.f -o tb_mem_ctl

./obj_dir/tb_mem_ctl 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== tb/mem_ctl_vectors.svh ====
/* Memory controller test steps
 * One row per bus operation with its address, data, size and expected value
 */
`ifndef mem_ctl_vectors_svh
`define mem_ctl_vectors_svh

typedef enum logic [2:0] {
    op_write,
    op_read,
    op_fetch,
    op_both,
    op_status
} op_e;

// op_both takes the fetch address from data, op_status drives busy from data bit 0
typedef struct packed {
    op_e                      op;
    mem_ctl_pkg::addr_t       addr;
    mem_ctl_pkg::word_t       data;
    mem_ctl_pkg::store_size_t size;
    logic                     rnd;
    mem_ctl_pkg::word_t       exp_val;
    logic [127:0]             name;
} step_t;

localparam int n_steps = 22;

// op, address, data, size (0 byte, 1 half, 2 word), random data, expected, name
step_t steps [n_steps] = '{
    '{op_write,  32'h0000_2000, 32'h1122_3344, 3'd2, 1'b0, 32'h0, "st_word_a"},
    '{op_write,  32'h0000_2004, 32'h0000_0000, 3'd2, 1'b1, 32'h0, "st_word_b"},
    '{op_write,  32'h0000_2008, 32'ha5a5_5a5a, 3'd2, 1'b0, 32'h0, "st_word_c"},
    '{op_read,   32'h0000_2004, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "ld_word_b"},
    '{op_write,  32'h0000_2002, 32'hdead_beef, 3'd1, 1'b0, 32'h0, "st_half"},
    '{op_write,  32'h0000_2005, 32'h0000_0000, 3'd0, 1'b1, 32'h0, "st_byte"},
    '{op_write,  32'h0000_2009, 32'h7766_5544, 3'd7, 1'b0, 32'h0, "st_odd_size"},
    '{op_read,   32'h0000_2000, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "ld_after_half"},
    '{op_read,   32'h0000_2004, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "ld_after_byte"},
    '{op_read,   32'h0000_2007, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "ld_unaligned"},
    '{op_fetch,  32'h0000_2000, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "fetch_a"},
    '{op_fetch,  32'h0000_2008, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "fetch_c"},
    '{op_both,   32'h0000_2004, 32'h0000_2000, 3'd2, 1'b0, 32'h0, "both_a"},
    '{op_write,  32'h0000_4000, 32'h0000_0000, 3'd2, 1'b1, 32'h0, "uart_data_wr"},
    '{op_write,  32'h0000_4004, 32'h0000_0002, 3'd2, 1'b0, 32'h0, "uart_ctrl_go"},
    '{op_write,  32'h0000_4004, 32'h0000_0001, 3'd2, 1'b0, 32'h0, "uart_ctrl_nogo"},
    '{op_status, 32'h0000_4004, 32'h0000_0001, 3'd2, 1'b0, 32'h0, "uart_busy_hi"},
    '{op_status, 32'h0000_4004, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "uart_busy_lo"},
    '{op_read,   32'h0000_4000, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "uart_data_rd"},
    // Aliases onto 0x2008 if the top address bits were dropped
    '{op_write,  32'h0000_6008, 32'hffff_ffff, 3'd2, 1'b0, 32'h0, "unmapped_wr"},
    '{op_both,   32'h0000_2008, 32'h0000_2004, 3'd2, 1'b0, 32'h0, "both_b"},
    '{op_read,   32'h0000_5000, 32'h0000_0000, 3'd2, 1'b0, 32'h0, "unmapped_rd"}
};

`endif

// ==== tb/tb_mem_ctl.sv ====
/* Memory controller testbench
 * Runs the step table through the core ports and checks against a byte model
 */
module tb_mem_ctl;

    localparam int ram_bytes      = 16384;
    localparam int idx_w          = $clog2(ram_bytes);
    localparam int timeout_cycles = 40;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     instr_req;
    mem_ctl_pkg::addr_t       instr_addr;
    mem_ctl_pkg::word_t       instr_data;
    logic                     instr_ready;
    mem_ctl_pkg::addr_t       mem_addr;
    mem_ctl_pkg::word_t       mem_wdata;
    mem_ctl_pkg::store_size_t mem_wflag;
    logic                     mem_we;
    logic                     mem_re;
    mem_ctl_pkg::word_t       mem_rdata;
    logic                     mem_ready;
    logic                     uart_tx_en;
    logic                     uart_tx_busy;
    mem_ctl_pkg::byte_t       uart_tx_data;

    `include "mem_ctl_vectors.svh"

    // Reference image of RAM
    mem_ctl_pkg::byte_t model [ram_bytes];
    int unsigned        pulses;

    always #20 clk = ~clk;

    mem_ctl mem_ctl_i (
        .clk, .rst_n, .instr_req, .instr_addr, .instr_data, .instr_ready,
        .mem_addr, .mem_wdata, .mem_wflag, .mem_we, .mem_re, .mem_rdata, .mem_ready,
        .uart_tx_en, .uart_tx_busy, .uart_tx_data
    );

    // ============================================================
    // Failure reporting and compares
    // ============================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input mem_ctl_pkg::word_t exp_w,
                              input mem_ctl_pkg::word_t act_w);
        if (act_w !== exp_w) begin
            abort_run($sformatf("** Error %s: expected %08h, actual %08h", name, exp_w, act_w));
        end
    endtask

    task automatic check_byte(input string name, input mem_ctl_pkg::byte_t exp_b,
                              input mem_ctl_pkg::byte_t act_b);
        if (act_b !== exp_b) begin
            abort_run($sformatf("** Error %s: expected %02h, actual %02h", name, exp_b, act_b));
        end
    endtask

    // ============================================================
    // Byte model
    // ============================================================
    function automatic logic in_ram(input mem_ctl_pkg::addr_t a);
        return (a >= mem_ctl_pkg::data_base) && (a < ram_bytes);
    endfunction

    task automatic model_write(input mem_ctl_pkg::addr_t a, input mem_ctl_pkg::word_t d,
                               input mem_ctl_pkg::store_size_t size);
        int                 n;
        logic [idx_w-1:0]   idx;
        n = (size == mem_ctl_pkg::size_word) ? 4 : (size == mem_ctl_pkg::size_half) ? 2 : 1;
        for (int i = 0; i < n; i++) begin
            idx        = idx_w'(a + mem_ctl_pkg::addr_t'(i));
            model[idx] = d[8*i +: 8];
        end
    endtask

    function automatic mem_ctl_pkg::word_t model_read(input mem_ctl_pkg::addr_t a);
        mem_ctl_pkg::word_t w;
        logic [idx_w-1:0]   idx;
        for (int i = 0; i < 4; i++) begin
            idx         = idx_w'(a + mem_ctl_pkg::addr_t'(i));
            w[8*i +: 8] = model[idx];
        end
        return w;
    endfunction

    // ============================================================
    // Bus driver
    // ============================================================
    // Called on a falling edge, returns on a falling edge after one idle cycle
    task automatic run_access(input logic fetch, input logic data, input logic we,
                              input mem_ctl_pkg::addr_t daddr, input mem_ctl_pkg::addr_t faddr,
                              input mem_ctl_pkg::word_t wdata,
                              input mem_ctl_pkg::store_size_t size,
                              output mem_ctl_pkg::word_t drd, output mem_ctl_pkg::word_t frd);
        int   cycles;
        logic data_open;
        logic fetch_open;
        data_open  = data;
        fetch_open = fetch;
        drd        = '0;
        frd        = '0;
        cycles     = 0;
        instr_req  = fetch;
        instr_addr = faddr;
        mem_addr   = daddr;
        mem_wdata  = wdata;
        mem_wflag  = size;
        mem_we     = data && we;
        mem_re     = data && !we;
        while (data_open || fetch_open) begin
            @(negedge clk);
            cycles++;
            if (uart_tx_en) pulses++;
            // Fetch side first so a ready pair in one cycle is caught
            if (instr_ready) begin
                if (data_open) abort_run("instr_ready came before mem_ready");
                if (!fetch_open) abort_run("instr_ready pulsed with no fetch open");
                frd        = instr_data;
                fetch_open = 1'b0;
                instr_req  = 1'b0;
            end
            if (mem_ready) begin
                if (!data_open) abort_run("mem_ready pulsed with no data request open");
                drd       = mem_rdata;
                data_open = 1'b0;
                mem_we    = 1'b0;
                mem_re    = 1'b0;
            end
            if (cycles > timeout_cycles) abort_run("timeout waiting for a ready pulse");
        end
        @(negedge clk);
        if (instr_ready || mem_ready || uart_tx_en) begin
            abort_run("ready or uart_tx_en still high after the access");
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        mem_ctl_pkg::word_t data;
        mem_ctl_pkg::word_t drd;
        mem_ctl_pkg::word_t frd;
        mem_ctl_pkg::addr_t addr;
        string              name;
        void'($urandom(32'had09f20e));
        rst_n        = 1'b0;
        instr_req    = 1'b0;
        instr_addr   = '0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_wflag    = '0;
        mem_we       = 1'b0;
        mem_re       = 1'b0;
        uart_tx_busy = 1'b0;
        pulses       = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (instr_ready || mem_ready || uart_tx_en) abort_run("strobe high during reset");
        check_word("reset_instr_data", '0, instr_data);
        check_word("reset_mem_rdata", '0, mem_rdata);
        check_byte("reset_uart_tx_data", '0, uart_tx_data);
        rst_n = 1'b1;

        foreach (steps[i]) begin
            name   = $sformatf("%0s", steps[i].name);
            addr   = steps[i].addr;
            data   = steps[i].rnd ? $urandom : steps[i].data;
            pulses = 0;
            case (steps[i].op)
                op_write: begin
                    run_access(1'b0, 1'b1, 1'b1, addr, '0, data, steps[i].size, drd, frd);
                    if (in_ram(addr)) model_write(addr, data, steps[i].size);
                    if (addr == mem_ctl_pkg::uart_data_addr) begin
                        check_byte(name, data[7:0], uart_tx_data);
                    end
                end
                op_read: begin
                    run_access(1'b0, 1'b1, 1'b0, addr, '0, '0, steps[i].size, drd, frd);
                    check_word(name, in_ram(addr) ? model_read(addr) : steps[i].exp_val, drd);
                end
                op_fetch: begin
                    run_access(1'b1, 1'b0, 1'b0, '0, addr, '0, steps[i].size, drd, frd);
                    check_word(name, model_read(addr), frd);
                end
                op_both: begin
                    run_access(1'b1, 1'b1, 1'b0, addr, data, '0, steps[i].size, drd, frd);
                    check_word(name, model_read(addr), drd);
                    check_word(name, model_read(data), frd);
                end
                default: begin
                    // Busy is sampled at the completion edge
                    uart_tx_busy = data[0];
                    run_access(1'b0, 1'b1, 1'b0, addr, '0, '0, steps[i].size, drd, frd);
                    check_word(name, {31'b0, data[0]}, drd);
                end
            endcase
            if (steps[i].op == op_write && addr == mem_ctl_pkg::uart_ctrl_addr) begin
                check_word(name, {31'b0, data[1]}, mem_ctl_pkg::word_t'(pulses));
            end else begin
                check_word(name, '0, mem_ctl_pkg::word_t'(pulses));
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
